/* hdl/bp_pkg.sv */
package bp_pkg;

    //////////////////////
    // widths
    //////////////////////

    // instruction address
    typedef logic [31:0] addr_t;

    // instruction word, compressed ones sit in the low half
    typedef logic [31:0] instr_t;

    // 2-bit saturating counter, msb set means taken
    typedef logic [1:0] ctr_t;

    //////////////////////
    // opcodes
    //////////////////////

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // quadrant 2 funct4 of c.jr, bit 12 set gives c.jalr
    localparam logic [3:0] CJR_FUNCT  = 4'b1000;

    //////////////////////
    // bundles
    //////////////////////

    // predecode flags for the fetched word
    typedef struct packed {
        logic is_branch;
        logic is_jump_reg;
        logic is_comp;
    } fetch_info_t;

    // one resolved control instruction from execute
    typedef struct packed {
        logic  valid;
        logic  is_branch;
        logic  is_jump_reg;
        addr_t pc;
        logic  taken;
        addr_t target;
        logic  mispredict;
    } resolve_t;

endpackage

/* hdl/fetch_predecode.sv */
`timescale 1ns/100ps

module fetch_predecode (
    input  bp_pkg::instr_t      i_instr,
    output bp_pkg::fetch_info_t o_info
);
    import bp_pkg::*;

    logic       comp;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] c_rs1;
    logic [4:0] c_rs2;
    logic       full_branch;
    logic       full_jalr;
    logic       comp_jr;

    //////////////////////
    // field split
    //////////////////////

    // anything but 2'b11 in the low bits is a 16-bit instruction
    assign comp   = (i_instr[1:0] != 2'b11);
    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];

    // compressed register fields of the cr format
    assign c_rs1 = i_instr[11:7];
    assign c_rs2 = i_instr[6:2];

    //////////////////////
    // classification
    //////////////////////

    // conditional branches by opcode alone
    assign full_branch = !comp && (opcode == OPC_BRANCH);

    // jalr only defines funct3 of zero
    assign full_jalr = !comp && (opcode == OPC_JALR) && (funct3 == 3'b000);

    // c.jr and c.jalr share funct4 except for bit 12
    // rs1 of zero is reserved or ebreak, rs2 nonzero is c.mv / c.add
    assign comp_jr = (i_instr[1:0] == 2'b10)
                     && ({i_instr[15:13], 1'b0} == CJR_FUNCT)
                     && (c_rs1 != 5'd0)
                     && (c_rs2 == 5'd0);

    assign o_info = '{
        is_branch:   full_branch,
        is_jump_reg: full_jalr || comp_jr,
        is_comp:     comp
    };

endmodule

/* hdl/global_history.sv */
`timescale 1ns/100ps

module global_history #(
    parameter int HIST_BITS = 8,
    parameter int IDX_W     = 5
) (
    input  logic                 clk_g,
    input  logic                 rst_g,
    input  logic                 i_push,
    input  logic                 i_push_bit,
    input  logic                 i_resolve,
    input  logic                 i_repair,
    input  logic                 i_repair_bit,
    output logic [HIST_BITS-1:0] o_hist,
    output logic [IDX_W-1:0]     o_ckpt_hist
);

    // speculative bits kept beyond the index window
    localparam int DEPTH = HIST_BITS - IDX_W;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [HIST_BITS-1:0] hist_q;
    logic [HIST_BITS-1:0] hist_d;
    logic [HIST_BITS-1:0] rewound;
    logic [CNT_W-1:0]     cnt_q;
    logic [CNT_W-1:0]     cnt_d;
    logic                 cnt_full;

    //////////////////////
    // checkpoint window
    //////////////////////

    // newest outcome at bit 0, every in-flight branch pushed one bit
    assign cnt_full = (cnt_q == CNT_W'(DEPTH));
    assign rewound  = hist_q >> cnt_q;

    assign o_hist      = hist_q;
    assign o_ckpt_hist = rewound[IDX_W-1:0];

    //////////////////////
    // next state
    //////////////////////

    always_comb begin
        hist_d = hist_q;
        cnt_d  = cnt_q;
        if (i_repair) begin
            // drop the younger guesses, keep the true outcome
            hist_d = {rewound[HIST_BITS-2:0], i_repair_bit};
            cnt_d  = '0;
        end else begin
            if (i_push) begin
                hist_d = {hist_q[HIST_BITS-2:0], i_push_bit};
            end
            // push and resolve together leave the count alone
            if (i_push && !i_resolve && !cnt_full) begin
                cnt_d = cnt_q + 1'b1;
            end else if (i_resolve && !i_push && (cnt_q != '0)) begin
                cnt_d = cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            hist_q <= '0;
            cnt_q  <= '0;
        end else begin
            hist_q <= hist_d;
            cnt_q  <= cnt_d;
        end
    end

endmodule

/* hdl/branch_target_table.sv */
`timescale 1ns/100ps

module branch_target_table #(
    parameter  int TABLE_ENTRIES = 32,
    localparam int IDX_W         = $clog2(TABLE_ENTRIES)
) (
    input  logic          clk_g,
    input  logic          rst_g,

    // lookup port
    input  logic [IDX_W-1:0] i_rd_idx,
    output bp_pkg::ctr_t     o_rd_ctr,
    output bp_pkg::addr_t    o_rd_target,

    // update port, also reads the old counter
    input  logic [IDX_W-1:0] i_wr_idx,
    output bp_pkg::ctr_t     o_wr_ctr,
    input  logic             i_wr_en,
    input  logic             i_wr_ctr_en,
    input  bp_pkg::ctr_t     i_wr_ctr,
    input  bp_pkg::addr_t    i_wr_target
);
    import bp_pkg::*;

    ctr_t  ctr_q    [TABLE_ENTRIES];
    addr_t target_q [TABLE_ENTRIES];

    //////////////////////
    // read ports
    //////////////////////

    // combinational, a write shows up on the next lookup
    assign o_rd_ctr    = ctr_q[i_rd_idx];
    assign o_rd_target = target_q[i_rd_idx];

    // old counter for the saturating step
    assign o_wr_ctr = ctr_q[i_wr_idx];

    //////////////////////
    // write port
    //////////////////////

    // counter and target written independently
    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                ctr_q[i]    <= '0;
                target_q[i] <= '0;
            end
        end else begin
            if (i_wr_ctr_en) begin
                ctr_q[i_wr_idx] <= i_wr_ctr;
            end
            if (i_wr_en) begin
                target_q[i_wr_idx] <= i_wr_target;
            end
        end
    end

endmodule

/* hdl/branch_predictor.sv */
`timescale 1ns/100ps

module branch_predictor #(
    parameter int TABLE_ENTRIES = 32,
    parameter int HIST_BITS     = 8
) (
    input  logic                clk_g,
    input  logic                rst_g,
    input  logic                i_fetch_valid,
    input  bp_pkg::addr_t       i_fetch_pc,
    input  bp_pkg::fetch_info_t i_info,
    input  bp_pkg::resolve_t    i_resolve,
    output logic                o_pred_taken,
    output bp_pkg::addr_t       o_pred_target
);
    import bp_pkg::*;

    localparam int IDX_W = $clog2(TABLE_ENTRIES);

    logic [HIST_BITS-1:0] hist;
    logic [IDX_W-1:0]     ckpt_hist;
    logic [IDX_W-1:0]     lookup_idx;
    logic [IDX_W-1:0]     update_idx;
    ctr_t                 lookup_ctr;
    ctr_t                 update_ctr;
    ctr_t                 next_ctr;
    addr_t                lookup_target;
    logic                 push;
    logic                 res_branch;
    logic                 res_jump;
    logic                 repair;
    logic                 wr_target_en;
    logic                 wr_ctr_en;

    //////////////////////
    // gshare indexes
    //////////////////////

    // pc bits 1:0 carry no information for 4-byte aligned branches
    assign lookup_idx = hist[IDX_W-1:0] ^ i_fetch_pc[IDX_W+1:2];
    assign update_idx = ckpt_hist ^ i_resolve.pc[IDX_W+1:2];

    //////////////////////
    // prediction
    //////////////////////

    // register jumps always go to the stored target
    assign o_pred_taken = i_fetch_valid
                          && (i_info.is_jump_reg || (i_info.is_branch && lookup_ctr[1]));
    assign o_pred_target = lookup_target;

    // speculative history push with the guessed direction
    assign push = i_fetch_valid && i_info.is_branch;

    //////////////////////
    // update
    //////////////////////

    assign res_branch = i_resolve.valid && i_resolve.is_branch;
    assign res_jump   = i_resolve.valid && i_resolve.is_jump_reg;
    assign repair     = res_branch && i_resolve.mispredict;

    // branches refresh the target on every resolve
    assign wr_target_en = res_branch || (res_jump && i_resolve.mispredict);
    assign wr_ctr_en    = repair;

    // one step toward the real outcome, saturating at 0 and 3
    always_comb begin
        next_ctr = update_ctr;
        if (i_resolve.taken) begin
            if (update_ctr != 2'b11) begin
                next_ctr = update_ctr + 2'b01;
            end
        end else if (update_ctr != 2'b00) begin
            next_ctr = update_ctr - 2'b01;
        end
    end

    global_history #(
        .HIST_BITS (HIST_BITS),
        .IDX_W     (IDX_W)
    ) u_history (
        .clk_g        (clk_g),
        .rst_g        (rst_g),
        .i_push       (push),
        .i_push_bit   (lookup_ctr[1]),
        .i_resolve    (res_branch),
        .i_repair     (repair),
        .i_repair_bit (i_resolve.taken),
        .o_hist       (hist),
        .o_ckpt_hist  (ckpt_hist)
    );

    branch_target_table #(
        .TABLE_ENTRIES (TABLE_ENTRIES)
    ) u_table (
        .clk_g       (clk_g),
        .rst_g       (rst_g),
        .i_rd_idx    (lookup_idx),
        .o_rd_ctr    (lookup_ctr),
        .o_rd_target (lookup_target),
        .i_wr_idx    (update_idx),
        .o_wr_ctr    (update_ctr),
        .i_wr_en     (wr_target_en),
        .i_wr_ctr_en (wr_ctr_en),
        .i_wr_ctr    (next_ctr),
        .i_wr_target (i_resolve.target)
    );

endmodule

/* hdl/fetch_pc_gen.sv */
`timescale 1ns/100ps

module fetch_pc_gen #(
    parameter bp_pkg::addr_t RESET_PC = '0
) (
    input  logic                clk_g,
    input  logic                rst_g,
    input  logic                i_fetch_valid,
    input  bp_pkg::addr_t       i_fetch_pc,
    input  bp_pkg::fetch_info_t i_info,
    input  logic                i_pred_taken,
    input  bp_pkg::addr_t       i_pred_target,
    input  bp_pkg::resolve_t    i_resolve,
    output bp_pkg::addr_t       o_next_pc
);
    import bp_pkg::*;

    addr_t next_pc_q;
    addr_t seq_pc;
    addr_t fetch_pc_next;
    addr_t redirect_pc;
    logic  is_ctrl;
    logic  redirect;

    //////////////////////
    // fetch path
    //////////////////////

    // 16-bit instructions step by two
    assign seq_pc  = i_fetch_pc + (i_info.is_comp ? 32'd2 : 32'd4);
    assign is_ctrl = i_info.is_branch || i_info.is_jump_reg;

    assign fetch_pc_next = (is_ctrl && i_pred_taken) ? i_pred_target : seq_pc;

    //////////////////////
    // redirect path
    //////////////////////

    assign redirect = i_resolve.valid && i_resolve.mispredict;

    // not taken only happens for branches, and those are full width
    assign redirect_pc = i_resolve.taken ? i_resolve.target : i_resolve.pc + 32'd4;

    // mispredict wins over a fetch in the same cycle
    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            next_pc_q <= RESET_PC;
        end else if (redirect) begin
            next_pc_q <= redirect_pc;
        end else if (i_fetch_valid) begin
            next_pc_q <= fetch_pc_next;
        end
    end

    assign o_next_pc = next_pc_q;

endmodule

/* hdl/fetch_predict_top.sv */
`timescale 1ns/100ps

module fetch_predict_top #(
    parameter int            TABLE_ENTRIES = 32,
    parameter int            HIST_BITS     = 8,
    parameter bp_pkg::addr_t RESET_PC      = '0
) (
    input  logic             clk_g,
    input  logic             rst_g,
    input  logic             i_fetch_valid,
    input  bp_pkg::addr_t    i_fetch_pc,
    input  bp_pkg::instr_t   i_fetch_instr,
    input  bp_pkg::resolve_t i_resolve,
    output bp_pkg::addr_t    o_next_pc,
    output logic             o_pred_taken,
    output bp_pkg::addr_t    o_pred_target
);
    import bp_pkg::*;

    fetch_info_t info;

    fetch_predecode u_predecode (
        .i_instr (i_fetch_instr),
        .o_info  (info)
    );

    branch_predictor #(
        .TABLE_ENTRIES (TABLE_ENTRIES),
        .HIST_BITS     (HIST_BITS)
    ) u_predictor (
        .clk_g         (clk_g),
        .rst_g         (rst_g),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_pc    (i_fetch_pc),
        .i_info        (info),
        .i_resolve     (i_resolve),
        .o_pred_taken  (o_pred_taken),
        .o_pred_target (o_pred_target)
    );

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk_g         (clk_g),
        .rst_g         (rst_g),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_pc    (i_fetch_pc),
        .i_info        (info),
        .i_pred_taken  (o_pred_taken),
        .i_pred_target (o_pred_target),
        .i_resolve     (i_resolve),
        .o_next_pc     (o_next_pc)
    );

endmodule

/* bench/fetch_predict_asserts.sv */
`timescale 1ns/100ps

module fetch_predict_asserts (
    input logic             clk_g,
    input logic             rst_g,
    input logic             o_pred_taken,
    input bp_pkg::addr_t    o_next_pc,
    input bp_pkg::resolve_t i_resolve
);
    import bp_pkg::*;

    // first lookup after reset sees cleared counters
    reset_quiet: assert property (@(posedge clk_g) $fell(rst_g) |=> !o_pred_taken)
        else $error("prediction raised right after reset");

    // fetch addresses stay halfword aligned
    pc_even: assert property (@(posedge clk_g) disable iff (rst_g) !o_next_pc[0])
        else $error("next pc is odd");

    // mispredict redirect lands one cycle later
    redirect_next: assert property (@(posedge clk_g) disable iff (rst_g)
        (i_resolve.valid && i_resolve.mispredict)
        |=> (o_next_pc == ($past(i_resolve.taken) ? $past(i_resolve.target)
                                                  : $past(i_resolve.pc) + 32'd4)))
        else $error("mispredict redirect missing");

endmodule

bind fetch_predict_top fetch_predict_asserts u_asserts (
    .clk_g        (clk_g),
    .rst_g        (rst_g),
    .o_pred_taken (o_pred_taken),
    .o_next_pc    (o_next_pc),
    .i_resolve    (i_resolve)
);

/* bench/tb_fetch_predict.sv */
`timescale 1ns/100ps

module tb_fetch_predict;
    import bp_pkg::*;

    localparam int    TABLE_ENTRIES = 32;
    localparam int    HIST_BITS     = 8;
    localparam int    IDX_W         = $clog2(TABLE_ENTRIES);
    localparam int    DEPTH         = HIST_BITS - IDX_W;
    localparam addr_t RESET_PC      = 32'h0000_0000;

    localparam instr_t INS_BEQ  = 32'h0020_8063;
    localparam instr_t INS_JALR = 32'h0000_8067;
    localparam instr_t INS_CJR  = 32'h0000_8082;
    localparam instr_t INS_CNOP = 32'h0000_0001;

    typedef struct {
        string    name;
        logic     fv;
        addr_t    pc;
        instr_t   instr;
        logic     br;
        logic     jr;
        logic     comp;
        resolve_t res;
        logic     chk;
    } row_t;

    logic     clk_g = 1'b0;
    logic     rst_g = 1'b1;
    logic     fetch_valid = 1'b0;
    addr_t    fetch_pc = '0;
    instr_t   fetch_instr = '0;
    resolve_t resolve = '0;
    addr_t    next_pc;
    logic     pred_taken;
    addr_t    pred_target;

    row_t     rows[$];
    int       cycles = 0;
    int       seed = 32'hbba4;

    // reference state
    ctr_t                 m_ctr [TABLE_ENTRIES];
    addr_t                m_tgt [TABLE_ENTRIES];
    logic [HIST_BITS-1:0] m_hist;
    int                   m_cnt;
    addr_t                m_next_pc;

    always #2 clk_g = ~clk_g;

    fetch_predict_top #(
        .TABLE_ENTRIES (TABLE_ENTRIES),
        .HIST_BITS     (HIST_BITS),
        .RESET_PC      (RESET_PC)
    ) u_dut (
        .clk_g         (clk_g),
        .rst_g         (rst_g),
        .i_fetch_valid (fetch_valid),
        .i_fetch_pc    (fetch_pc),
        .i_fetch_instr (fetch_instr),
        .i_resolve     (resolve),
        .o_next_pc     (next_pc),
        .o_pred_taken  (pred_taken),
        .o_pred_target (pred_target)
    );

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (exp !== act) begin
            fail_run($sformatf("Error %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_taken(string name, logic exp, logic act);
        if (exp !== act) begin
            fail_run($sformatf("Error %s: expected %b actual %b", name, exp, act));
        end
    endtask

    always @(posedge clk_g) begin
        cycles <= cycles + 1;
        if (cycles > rows.size() + 20) begin
            fail_run("simulation ran past its cycle limit without finishing");
        end
    end

    //////////////////////
    // table building
    //////////////////////

    function automatic resolve_t mk_res(logic br, logic jr, addr_t pc, logic taken,
                                        addr_t target, logic misp);
        return '{valid: 1'b1, is_branch: br, is_jump_reg: jr, pc: pc,
                 taken: taken, target: target, mispredict: misp};
    endfunction

    // non-control OP-IMM word with random fields
    function automatic instr_t filler();
        instr_t w;
        w = $random(seed);
        return {w[31:7], 7'b0010011};
    endfunction

    task automatic add_row(string name, logic fv, addr_t pc, instr_t instr, logic br,
                           logic jr, logic comp, resolve_t res);
        row_t r;
        r.name  = name;
        r.fv    = fv;
        r.pc    = pc;
        r.instr = instr;
        r.br    = br;
        r.jr    = jr;
        r.comp  = comp;
        r.res   = res;
        r.chk   = fv;
        rows.push_back(r);
    endtask

    task automatic add_resolve(string name, logic br, addr_t pc, logic taken, addr_t tgt);
        add_row(name, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, mk_res(br, !br, pc, taken, tgt, 1'b1));
    endtask

    //////////////////////
    // reference model
    //////////////////////

    task automatic model_predict(row_t r, output logic taken, output addr_t tgt);
        logic [IDX_W-1:0] idx;
        idx   = m_hist[IDX_W-1:0] ^ r.pc[IDX_W+1:2];
        taken = r.fv && (r.jr || (r.br && m_ctr[idx][1]));
        tgt   = m_tgt[idx];
    endtask

    task automatic model_step(row_t r);
        logic [HIST_BITS-1:0] rew;
        logic [IDX_W-1:0]     ui;
        logic                 pt;
        addr_t                ptgt;
        logic                 push;
        logic                 res_br;
        logic                 repair;
        model_predict(r, pt, ptgt);
        rew    = m_hist >> m_cnt;
        ui     = rew[IDX_W-1:0] ^ r.res.pc[IDX_W+1:2];
        push   = r.fv && r.br;
        res_br = r.res.valid && r.res.is_branch;
        repair = res_br && r.res.mispredict;
        // resolves in this table are full width, so fall-through is pc+4
        if (r.res.valid && r.res.mispredict) begin
            m_next_pc = r.res.taken ? r.res.target : r.res.pc + 32'd4;
        end else if (r.fv) begin
            m_next_pc = ((r.br || r.jr) && pt) ? ptgt : r.pc + (r.comp ? 32'd2 : 32'd4);
        end
        if (res_br || (r.res.valid && r.res.is_jump_reg && r.res.mispredict)) begin
            m_tgt[ui] = r.res.target;
        end
        if (repair) begin
            if (r.res.taken && m_ctr[ui] != 2'd3) begin
                m_ctr[ui] = m_ctr[ui] + 2'd1;
            end else if (!r.res.taken && m_ctr[ui] != 2'd0) begin
                m_ctr[ui] = m_ctr[ui] - 2'd1;
            end
            m_hist = {rew[HIST_BITS-2:0], r.res.taken};
            m_cnt  = 0;
        end else begin
            if (push) begin
                m_hist = {m_hist[HIST_BITS-2:0], pt};
            end
            if (push && !res_br && m_cnt < DEPTH) begin
                m_cnt++;
            end else if (res_br && !push && m_cnt > 0) begin
                m_cnt--;
            end
        end
    endtask

    //////////////////////
    // main sequence
    //////////////////////

    initial begin
        logic  exp_taken;
        addr_t exp_tgt;
        addr_t rpc;
        add_row("reset_branch", 1, 32'h100, INS_BEQ, 1, 0, 0, '0);
        add_row("full_step", 1, 32'h104, filler(), 0, 0, 0, '0);
        add_row("comp_step", 1, 32'h108, INS_CNOP, 0, 0, 1, '0);
        add_row("branch_resolve", 0, '0, '0, 0, 0, 0, mk_res(1, 0, 32'h100, 0, 32'h200, 0));
        add_row("jalr_stored", 1, 32'h140, INS_JALR, 0, 1, 0, '0);
        add_row("jalr_mispredict", 1, 32'h144, filler(), 0, 0, 0,
                mk_res(0, 1, 32'h140, 1, 32'h400, 1));
        add_row("jalr_new_target", 1, 32'h140, INS_JALR, 0, 1, 0, '0);
        add_row("cjr_new_target", 1, 32'h140, INS_CJR, 0, 1, 1, '0);
        // taken repairs fill the history with ones so it stops moving
        // pc keeps these entries clear of the one 0x180 trains below
        for (int i = 0; i < 5; i++) begin
            add_resolve("hist_fill", 1, 32'h1c4, 1, 32'h1e0);
        end
        add_resolve("ctr_up_1", 1, 32'h180, 1, 32'h300);
        add_resolve("ctr_up_2", 1, 32'h180, 1, 32'h300);
        add_row("taken_after_two", 1, 32'h180, INS_BEQ, 1, 0, 0, '0);
        add_resolve("ctr_sat_1", 1, 32'h180, 1, 32'h300);
        add_resolve("ctr_sat_2", 1, 32'h180, 1, 32'h300);
        add_resolve("ctr_down_1", 1, 32'h180, 0, 32'h300);
        // each not-taken repair shifts a zero in, pc moves to stay on the same entry
        add_resolve("ctr_down_2", 1, 32'h184, 0, 32'h300);
        add_row("not_taken_after", 1, 32'h18c, INS_BEQ, 1, 0, 0, '0);
        add_row("redirect_taken", 1, 32'h300, filler(), 0, 0, 0,
                mk_res(1, 0, 32'h180, 1, 32'h340, 1));
        add_row("redirect_fall", 1, 32'h344, INS_BEQ, 1, 0, 0,
                mk_res(1, 0, 32'h180, 0, 32'h340, 1));
        add_row("spec_a", 1, 32'h200, INS_BEQ, 1, 0, 0, '0);
        add_row("spec_b", 1, 32'h220, INS_BEQ, 1, 0, 0, '0);
        // probe lands on the entry spec_a trains once the repair restores history
        add_row("spec_probe_1", 1, 32'h25c, INS_BEQ, 1, 0, 0, '0);
        add_resolve("repair_old", 1, 32'h200, 1, 32'h260);
        add_row("spec_probe_2", 1, 32'h25c, INS_BEQ, 1, 0, 0, '0);
        for (int i = 0; i < 4; i++) begin
            rpc = $random(seed);
            add_row("random_filler", 1, {rpc[31:2], 2'b00}, filler(), 0, 0, 0, '0);
        end

        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            m_ctr[i] = '0;
            m_tgt[i] = '0;
        end
        m_hist    = '0;
        m_cnt     = 0;
        m_next_pc = RESET_PC;

        repeat (3) @(posedge clk_g);
        rst_g <= 1'b0;

        foreach (rows[i]) begin
            @(posedge clk_g);
            fetch_valid <= rows[i].fv;
            fetch_pc    <= rows[i].pc;
            fetch_instr <= rows[i].instr;
            resolve     <= rows[i].res;
            @(negedge clk_g);
            check_addr({rows[i].name, " next_pc"}, m_next_pc, next_pc);
            if (rows[i].chk) begin
                model_predict(rows[i], exp_taken, exp_tgt);
                check_taken({rows[i].name, " taken"}, exp_taken, pred_taken);
                check_addr({rows[i].name, " target"}, exp_tgt, pred_target);
            end
            model_step(rows[i]);
        end

        @(posedge clk_g);
        fetch_valid <= 1'b0;
        resolve     <= '0;
        @(negedge clk_g);
        check_addr("final next_pc", m_next_pc, next_pc);
        $display("TEST PASS");
        $finish;
    end

endmodule

/* tb.f */
hdl/bp_pkg.sv
hdl/fetch_predecode.sv
hdl/global_history.sv
hdl/branch_target_table.sv
hdl/branch_predictor.sv
hdl/fetch_pc_gen.sv
hdl/fetch_predict_top.sv
bench/fetch_predict_asserts.sv
bench/tb_fetch_predict.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_predict
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
